// File: build.f
+incdir+include
src/ctrl_pkg.sv
src/cmd_if.sv
src/fx_if.sv
src/rx_ctrl_top.sv
src/tx_ctrl_top.sv
src/factory_ctrl.sv
src/fx_bc.sv
src/cfg_reg.sv
src/control_top.sv
tb/tb_control_top.sv

// File: include/ctrl_config.svh
// line and register constants; CTRL_BIT_US must be at least 1, ids are 8 bit
`ifndef CTRL_CONFIG_SVH
`define CTRL_CONFIG_SVH

// ----------------------------------------
// line timing
// ----------------------------------------
// pluse_us strobes per line bit
`define CTRL_BIT_US 4

// ----------------------------------------
// ids and identity
// ----------------------------------------
// device id that every board accepts
`define CTRL_BCAST_ID 8'hFF
// dev_id after reset
`define CTRL_DEV_ID_RST 8'h01
// value returned by reg_version
`define CTRL_VERSION 8'h25

`endif

// File: run.sh
#!/usr/bin/env bash
# compile and run the control_top testbench with Verilator, result decided from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_control_top -f build.f -o tb_control_top > sim.log 2>&1 \
  && ./obj_dir/tb_control_top >> sim.log 2>&1

grep -q "ALL TESTS PASSED" sim.log \
  && { echo "simulation passed, see sim.log"; exit 0; } \
  || { echo "simulation failed, see sim.log"; exit 1; }

// File: src/cfg_reg.sv
// decodes module 0 only; other modules read back zero so external q passes
`include "ctrl_config.svh"

module cfg_reg (
  fx_if.slave        bus,
  input  logic [5:0] mod_id,
  output logic [7:0] dev_id,
  input  logic       clk_sys,
  input  logic       rst_n
);

  import ctrl_pkg::*;

  logic [7:0] scratch;
  logic       wr_cfg;
  logic       rd_cfg;

  assign wr_cfg = bus.wr && (bus.waddr[15:8] == cfg_mod);
  assign rd_cfg = bus.rd && (bus.raddr[15:8] == cfg_mod);

  // ----------------------------------------
  // writable registers
  // ----------------------------------------
  always_ff @(posedge clk_sys) begin
    if (!rst_n) begin
      dev_id  <= `CTRL_DEV_ID_RST;
      scratch <= 8'h00;
    end else if (wr_cfg) begin
      case (bus.waddr[7:0])
        {1'b0, reg_dev_id}:  dev_id  <= bus.data;
        {1'b0, reg_scratch}: scratch <= bus.data;
        default: ;
      endcase
    end
  end

  // ----------------------------------------
  // read mux, q one cycle after rd
  // ----------------------------------------
  always_ff @(posedge clk_sys) begin
    if (rd_cfg) begin
      case (bus.raddr[7:0])
        {1'b0, reg_dev_id}:  bus.q <= dev_id;
        {1'b0, reg_mod_id}:  bus.q <= {2'b00, mod_id};
        {1'b0, reg_scratch}: bus.q <= scratch;
        {1'b0, reg_version}: bus.q <= `CTRL_VERSION;
        default:             bus.q <= 8'h00;
      endcase
    end else begin
      bus.q <= 8'h00;
    end
  end

endmodule

// File: src/cmd_if.sv
// one command strobe; fields are only valid while vld is high, no back-pressure
interface cmd_if;

  logic [7:0] dev;
  logic [7:0] mod;
  logic [7:0] addr;
  logic [7:0] data;
  logic       vld;

  // sender side
  modport src (
    output dev, mod, addr, data, vld
  );

  // receiver side
  modport dst (
    input dev, mod, addr, data, vld
  );

endinterface

// File: src/control_top.sv
// slave board control path; no mcu port, no bus monitor, commands are never retried
module control_top (
  // rs-485 line
  output logic        tx_ctrl,
  input  logic        rx_ctrl,
  // fx bus
  output logic [15:0] fx_waddr,
  output logic        fx_wr,
  output logic [7:0]  fx_data,
  output logic        fx_rd,
  output logic [15:0] fx_raddr,
  input  logic [7:0]  fx_q,
  // board identity
  output logic [7:0]  dev_id,
  input  logic [5:0]  mod_id,
  // clock and reset
  input  logic        clk_sys,
  input  logic        pluse_us,
  input  logic        rst_n
);

  // ----------------------------------------
  // internal links
  // ----------------------------------------
  cmd_if cmdr ();
  cmd_if cmdt ();
  cmd_if cmdl ();
  fx_if  fx_int ();

  logic [7:0] rd_data;
  logic       rd_vld;

  rx_ctrl_top u_rx_ctrl (
    .rx_ctrl  (rx_ctrl),
    .cmdr     (cmdr),
    .clk_sys  (clk_sys),
    .pluse_us (pluse_us),
    .rst_n    (rst_n)
  );

  factory_ctrl u_factory_ctrl (
    .cmdr    (cmdr),
    .cmdt    (cmdt),
    .cmdl    (cmdl),
    .rd_data (rd_data),
    .rd_vld  (rd_vld),
    .dev_id  (dev_id),
    .clk_sys (clk_sys),
    .rst_n   (rst_n)
  );

  tx_ctrl_top u_tx_ctrl (
    .tx_ctrl  (tx_ctrl),
    .cmdt     (cmdt),
    .clk_sys  (clk_sys),
    .pluse_us (pluse_us),
    .rst_n    (rst_n)
  );

  fx_bc u_fx_bc (
    .cmdl    (cmdl),
    .bus     (fx_int),
    .fx_q    (fx_q),
    .rd_data (rd_data),
    .rd_vld  (rd_vld),
    .clk_sys (clk_sys),
    .rst_n   (rst_n)
  );

  cfg_reg u_cfg_reg (
    .bus     (fx_int),
    .mod_id  (mod_id),
    .dev_id  (dev_id),
    .clk_sys (clk_sys),
    .rst_n   (rst_n)
  );

  // bus outputs to the board
  assign fx_waddr = fx_int.waddr;
  assign fx_wr    = fx_int.wr;
  assign fx_data  = fx_int.data;
  assign fx_rd    = fx_int.rd;
  assign fx_raddr = fx_int.raddr;

endmodule

// File: src/ctrl_pkg.sv
// command format and module 0 register map; only module 0 is decoded locally
package ctrl_pkg;

  // one command, dev byte goes out first
  typedef struct packed {
    logic [7:0] dev;
    logic [7:0] mod;
    logic [7:0] addr;
    logic [7:0] data;
  } cmd_t;

  // addr bit 7 marks a read, bits below it are the register address
  localparam int rd_flag = 7;

  // ----------------------------------------
  // local register map
  // ----------------------------------------
  localparam logic [7:0] cfg_mod     = 8'h00;
  localparam logic [6:0] reg_dev_id  = 7'd0;
  localparam logic [6:0] reg_mod_id  = 7'd1;
  localparam logic [6:0] reg_scratch = 7'd2;
  localparam logic [6:0] reg_version = 7'd3;

  // byte reversal between cmd_t and line order
  // bit 0 of the result is the first payload bit, dev[0]
  // the mapping is its own inverse
  function automatic logic [31:0] line_order(input logic [31:0] v);
    return {v[7:0], v[15:8], v[23:16], v[31:24]};
  endfunction

endpackage

// File: src/factory_ctrl.sv
// frames from rx are ignored while a local read is pending; no error replies
`include "ctrl_config.svh"

module factory_ctrl (
  cmd_if.dst         cmdr,
  cmd_if.src         cmdt,
  cmd_if.src         cmdl,
  input  logic [7:0] rd_data,
  input  logic       rd_vld,
  input  logic [7:0] dev_id,
  input  logic       clk_sys,
  input  logic       rst_n
);

  import ctrl_pkg::*;

  typedef enum logic {
    st_idle,
    st_wait_read
  } state_t;

  state_t state;
  cmd_t   in_cmd;
  cmd_t   t_cmd;
  cmd_t   l_cmd;
  logic   t_vld;
  logic   l_vld;
  logic   is_bc;
  logic   is_me;
  logic   is_rd;
  logic   do_fwd;
  logic   do_loc;

  assign in_cmd = {cmdr.dev, cmdr.mod, cmdr.addr, cmdr.data};
  assign is_bc  = (in_cmd.dev == `CTRL_BCAST_ID);
  assign is_me  = (in_cmd.dev == dev_id);
  assign is_rd  = in_cmd.addr[rd_flag];

  // ----------------------------------------
  // routing decode
  // ----------------------------------------
  always_comb begin
    do_fwd = 1'b0;
    do_loc = 1'b0;
    if (is_bc) begin
      // broadcast always travels on, reads are not answered
      do_fwd = 1'b1;
      do_loc = !is_rd;
    end else if (is_me) begin
      do_loc = 1'b1;
    end else begin
      do_fwd = 1'b1;
    end
  end

  // ----------------------------------------
  // control fsm
  // ----------------------------------------
  always_ff @(posedge clk_sys) begin
    if (!rst_n) begin
      state <= st_idle;
      t_vld <= 1'b0;
      l_vld <= 1'b0;
    end else begin
      t_vld <= 1'b0;
      l_vld <= 1'b0;
      case (state)
        st_idle: begin
          if (cmdr.vld) begin
            t_vld <= do_fwd;
            l_vld <= do_loc;
            if (do_loc && is_rd) begin
              state <= st_wait_read;
            end
          end
        end
        st_wait_read: begin
          if (rd_vld) begin
            t_vld <= 1'b1;
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // command payloads; l_cmd keeps mod and addr for the reply
  always_ff @(posedge clk_sys) begin
    if (state == st_idle && cmdr.vld) begin
      if (do_fwd) begin
        t_cmd <= in_cmd;
      end
      if (do_loc) begin
        l_cmd <= in_cmd;
      end
    end else if (state == st_wait_read && rd_vld) begin
      t_cmd <= {dev_id, l_cmd.mod, l_cmd.addr, rd_data};
    end
  end

  assign cmdt.dev  = t_cmd.dev;
  assign cmdt.mod  = t_cmd.mod;
  assign cmdt.addr = t_cmd.addr;
  assign cmdt.data = t_cmd.data;
  assign cmdt.vld  = t_vld;

  assign cmdl.dev  = l_cmd.dev;
  assign cmdl.mod  = l_cmd.mod;
  assign cmdl.addr = l_cmd.addr;
  assign cmdl.data = l_cmd.data;
  assign cmdl.vld  = l_vld;

  // read data from fx_bc only answers a read issued here
  a_rd_in_wait: assert property (@(posedge clk_sys) disable iff (!rst_n)
    rd_vld |-> state == st_wait_read);

endmodule

// File: src/fx_bc.sv
// single outstanding cycle; external slaves must return q the cycle after rd
module fx_bc (
  cmd_if.dst         cmdl,
  fx_if.master       bus,
  input  logic [7:0] fx_q,
  output logic [7:0] rd_data,
  output logic       rd_vld,
  input  logic       clk_sys,
  input  logic       rst_n
);

  import ctrl_pkg::*;

  logic        is_rd;
  logic        rd_d;
  logic [15:0] addr_w;

  assign is_rd = cmdl.addr[rd_flag];
  // mod in the high byte, register address in the low byte
  assign addr_w = {cmdl.mod, 1'b0, cmdl.addr[rd_flag-1:0]};

  // ----------------------------------------
  // bus strobes
  // ----------------------------------------
  always_ff @(posedge clk_sys) begin
    if (!rst_n) begin
      bus.wr <= 1'b0;
      bus.rd <= 1'b0;
      rd_d   <= 1'b0;
      rd_vld <= 1'b0;
    end else begin
      bus.wr <= cmdl.vld && !is_rd;
      bus.rd <= cmdl.vld && is_rd;
      // q is on the bus while rd_d is high
      rd_d   <= bus.rd;
      rd_vld <= rd_d;
    end
  end

  // addresses, write data and captured read data
  always_ff @(posedge clk_sys) begin
    if (cmdl.vld) begin
      if (is_rd) begin
        bus.raddr <= addr_w;
      end else begin
        bus.waddr <= addr_w;
        bus.data  <= cmdl.data;
      end
    end
    if (rd_d) begin
      // unselected slaves drive zero
      rd_data <= fx_q | bus.q;
    end
  end

endmodule

// File: src/fx_if.sv
// internal fx bus; q is valid the cycle after rd and must read zero when unselected
interface fx_if;

  logic [15:0] waddr;
  logic        wr;
  logic [7:0]  data;
  logic        rd;
  logic [15:0] raddr;
  logic [7:0]  q;

  // bus controller
  modport master (
    output waddr, wr, data, rd, raddr,
    input  q
  );

  // register block
  modport slave (
    input  waddr, wr, data, rd, raddr,
    output q
  );

endinterface

// File: src/rx_ctrl_top.sv
// line idles high; a frame with a low stop bit is dropped without any report
`include "ctrl_config.svh"

module rx_ctrl_top (
  input  logic rx_ctrl,
  cmd_if.src   cmdr,
  input  logic clk_sys,
  input  logic pluse_us,
  input  logic rst_n
);

  import ctrl_pkg::*;

  localparam int pw = $clog2(`CTRL_BIT_US + 1);
  // first sample lands in the middle of the start bit
  localparam logic [pw-1:0] half = pw'((`CTRL_BIT_US + 1) / 2);

  logic          rx_s1;
  logic          rx_s2;
  logic          rx_s3;
  logic          fall;
  logic          busy;
  logic          smp;
  logic [pw-1:0] pcnt;
  logic [5:0]    bcnt;
  logic [31:0]   sh;
  logic          vld_q;
  cmd_t          cmd_q;

  assign fall = rx_s3 && !rx_s2;
  assign smp  = busy && pluse_us && (pcnt == pw'(1));

  // ----------------------------------------
  // sync, start detect and bit timing
  // ----------------------------------------
  always_ff @(posedge clk_sys) begin
    if (!rst_n) begin
      rx_s1 <= 1'b1;
      rx_s2 <= 1'b1;
      rx_s3 <= 1'b1;
      busy  <= 1'b0;
      pcnt  <= '0;
      bcnt  <= '0;
      vld_q <= 1'b0;
    end else begin
      rx_s1 <= rx_ctrl;
      rx_s2 <= rx_s1;
      rx_s3 <= rx_s2;
      vld_q <= 1'b0;
      if (!busy) begin
        if (fall) begin
          busy <= 1'b1;
          pcnt <= half;
          bcnt <= '0;
        end
      end else if (smp) begin
        pcnt <= pw'(`CTRL_BIT_US);
        bcnt <= bcnt + 6'd1;
        if (bcnt == 6'd0 && rx_s2) begin
          // glitch, not a start bit
          busy <= 1'b0;
        end else if (bcnt == 6'd33) begin
          busy  <= 1'b0;
          vld_q <= rx_s2;
        end
      end else if (pluse_us) begin
        pcnt <= pcnt - 1'b1;
      end
    end
  end

  // payload shift, first bit ends up in sh[0]
  always_ff @(posedge clk_sys) begin
    if (smp && bcnt >= 6'd1 && bcnt <= 6'd32) begin
      sh <= {rx_s2, sh[31:1]};
    end
    if (smp && bcnt == 6'd33) begin
      cmd_q <= cmd_t'(line_order(sh));
    end
  end

  assign cmdr.dev  = cmd_q.dev;
  assign cmdr.mod  = cmd_q.mod;
  assign cmdr.addr = cmd_q.addr;
  assign cmdr.data = cmd_q.data;
  assign cmdr.vld  = vld_q;

  // one command per frame, never back to back
  a_vld_single: assert property (@(posedge clk_sys) disable iff (!rst_n)
    cmdr.vld |=> !cmdr.vld);

endmodule

// File: src/tx_ctrl_top.sv
// one frame at a time; a command that arrives during a frame is lost
`include "ctrl_config.svh"

module tx_ctrl_top (
  output logic tx_ctrl,
  cmd_if.dst   cmdt,
  input  logic clk_sys,
  input  logic pluse_us,
  input  logic rst_n
);

  import ctrl_pkg::*;

  localparam int pw = $clog2(`CTRL_BIT_US + 1);

  cmd_t          cmd_in;
  logic [33:0]   sh;
  logic          busy;
  logic          emit;
  logic [pw-1:0] pcnt;
  logic [5:0]    bcnt;

  assign cmd_in = {cmdt.dev, cmdt.mod, cmdt.addr, cmdt.data};
  // next bit goes out on this pulse
  assign emit = busy && pluse_us && (pcnt == '0) && (bcnt != 6'd34);

  // ----------------------------------------
  // frame timing
  // ----------------------------------------
  always_ff @(posedge clk_sys) begin
    if (!rst_n) begin
      tx_ctrl <= 1'b1;
      busy    <= 1'b0;
      pcnt    <= '0;
      bcnt    <= '0;
    end else if (!busy) begin
      busy <= cmdt.vld;
      pcnt <= '0;
      bcnt <= '0;
    end else if (pluse_us) begin
      if (pcnt != '0) begin
        pcnt <= pcnt - 1'b1;
      end else if (bcnt == 6'd34) begin
        // stop bit has run its full period
        busy <= 1'b0;
      end else begin
        tx_ctrl <= sh[0];
        bcnt    <= bcnt + 6'd1;
        pcnt    <= pw'(`CTRL_BIT_US - 1);
      end
    end
  end

  // start bit in sh[0], stop bit in sh[33]
  always_ff @(posedge clk_sys) begin
    if (!busy && cmdt.vld) begin
      sh <= {1'b1, line_order(cmd_in), 1'b0};
    end else if (emit) begin
      sh <= {1'b1, sh[33:1]};
    end
  end

  // forward and reply traffic must leave a frame time between commands
  a_no_overrun: assert property (@(posedge clk_sys) disable iff (!rst_n)
    cmdt.vld |-> !busy);

endmodule

// File: tb/tb_control_top.sv
// pluse_us comes every 4 clocks; each row waits fixed frame times, so only one command is in flight
`include "ctrl_config.svh"

module tb_control_top;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int bit_clks   = `CTRL_BIT_US * 4;
  localparam int frame_clks = 34 * bit_clks;
  localparam longint frame_ns = 100 * frame_clks;
  localparam logic [5:0] board_mod = 6'h2B;
  localparam logic [7:0] id_new    = 8'h3C;

  typedef struct packed {
    logic [31:0] frame;
    logic        has_tx;
    logic [31:0] tx;
    logic        has_wr;
    logic [23:0] wr;
    logic        has_rd;
    logic [7:0]  id;
  } row_t;

  logic        clk_sys  = 1'b0;
  logic        rst_n    = 1'b0;
  logic        pluse_us = 1'b0;
  logic        rx_ctrl  = 1'b1;
  logic [7:0]  fx_q     = 8'h00;
  logic [5:0]  mod_id   = board_mod;
  logic        tx_ctrl;
  logic [15:0] fx_waddr;
  logic        fx_wr;
  logic [7:0]  fx_data;
  logic        fx_rd;
  logic [15:0] fx_raddr;
  logic [7:0]  dev_id;

  logic [1:0]  pdiv = 2'd0;
  logic [31:0] lcg_state = 32'h7df64a18;
  logic        table_built = 1'b0;
  row_t        rows[$];
  logic [31:0] tx_q[$];
  logic [23:0] wr_q[$];
  logic [15:0] rd_q[$];
  int          errors = 0;
  int          frame_errors = 0;
  int          checks = 0;

  control_top DUT (
    .tx_ctrl  (tx_ctrl),
    .rx_ctrl  (rx_ctrl),
    .fx_waddr (fx_waddr),
    .fx_wr    (fx_wr),
    .fx_data  (fx_data),
    .fx_rd    (fx_rd),
    .fx_raddr (fx_raddr),
    .fx_q     (fx_q),
    .dev_id   (dev_id),
    .mod_id   (mod_id),
    .clk_sys  (clk_sys),
    .pluse_us (pluse_us),
    .rst_n    (rst_n)
  );

  // ----------------------------------------
  // clock, microsecond strobe
  // ----------------------------------------
  initial begin
    forever #50 clk_sys = ~clk_sys;
  end

  always @(posedge clk_sys) begin
    pdiv     <= pdiv + 2'd1;
    pluse_us <= (pdiv == 2'd3);
  end

  // external fx slave, answers every module except 0
  always @(posedge clk_sys) begin
    if (fx_rd && fx_raddr[15:8] != 8'h00) begin
      fx_q <= fx_raddr[7:0] ^ 8'h5A;
    end else begin
      fx_q <= 8'h00;
    end
    if (rst_n && fx_wr) begin
      wr_q.push_back({fx_waddr, fx_data});
    end
    if (rst_n && fx_rd) begin
      rd_q.push_back(fx_raddr);
    end
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  function automatic logic [7:0] lcg_byte();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[23:16];
  endfunction

  function automatic logic [31:0] make_cmd(input logic [7:0] dev, input logic [7:0] mod,
                                           input logic [7:0] addr, input logic [7:0] data);
    return {dev, mod, addr, data};
  endfunction

  // fx bus address of a command, mod high, register address low
  function automatic logic [15:0] bus_addr(input logic [31:0] f);
    return {f[23:16], 1'b0, f[14:8]};
  endfunction

  // payload bit n on the line, dev byte first, LSB first
  function automatic int line_index(input int n);
    return 24 - 8 * (n / 8) + (n % 8);
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic send_frame(input logic [31:0] f);
    logic b;
    for (int i = 0; i < 34; i++) begin
      if (i == 0) begin
        b = 1'b0;
      end else if (i == 33) begin
        b = 1'b1;
      end else begin
        b = f[line_index(i - 1)];
      end
      rx_ctrl <= b;
      repeat (bit_clks) @(posedge clk_sys);
    end
  endtask

  task automatic add_row(input logic [31:0] frame, input logic has_tx, input logic [31:0] tx,
                         input logic has_wr, input logic [23:0] wr, input logic has_rd,
                         input logic [7:0] id);
    rows.push_back({frame, has_tx, tx, has_wr, wr, has_rd, id});
  endtask

  task automatic build_table();
    logic [7:0] id0;
    logic [7:0] d;
    logic [7:0] sc;
    id0 = `CTRL_DEV_ID_RST;
    // other devices pass through, reads too
    d = lcg_byte();
    add_row(make_cmd(8'h07, 8'h05, 8'h12, d), 1, make_cmd(8'h07, 8'h05, 8'h12, d),
            0, 24'h0, 0, id0);
    d = lcg_byte();
    add_row(make_cmd(8'h02, 8'h00, 8'h81, d), 1, make_cmd(8'h02, 8'h00, 8'h81, d),
            0, 24'h0, 0, id0);
    // local write and read on module 5
    d = lcg_byte();
    add_row(make_cmd(id0, 8'h05, 8'h34, d), 0, 32'h0, 1, {16'h0534, d}, 0, id0);
    d = lcg_byte();
    add_row(make_cmd(id0, 8'h05, 8'hC6, d), 1, make_cmd(id0, 8'h05, 8'hC6, 8'h46 ^ 8'h5A),
            0, 24'h0, 1, id0);
    // identity registers
    d = lcg_byte();
    add_row(make_cmd(id0, 8'h00, 8'h81, d), 1, make_cmd(id0, 8'h00, 8'h81, {2'b00, board_mod}),
            0, 24'h0, 1, id0);
    d = lcg_byte();
    add_row(make_cmd(id0, 8'h00, 8'h83, d), 1, make_cmd(id0, 8'h00, 8'h83, `CTRL_VERSION),
            0, 24'h0, 1, id0);
    // new device id, then old id is foreign
    add_row(make_cmd(id0, 8'h00, 8'h00, id_new), 0, 32'h0, 1, {16'h0000, id_new}, 0, id_new);
    d = lcg_byte();
    add_row(make_cmd(id_new, 8'h00, 8'h80, d), 1, make_cmd(id_new, 8'h00, 8'h80, id_new),
            0, 24'h0, 1, id_new);
    d = lcg_byte();
    add_row(make_cmd(id0, 8'h05, 8'h12, d), 1, make_cmd(id0, 8'h05, 8'h12, d),
            0, 24'h0, 0, id_new);
    // broadcast write lands in scratch and travels on
    sc = lcg_byte();
    add_row(make_cmd(`CTRL_BCAST_ID, 8'h00, 8'h02, sc), 1,
            make_cmd(`CTRL_BCAST_ID, 8'h00, 8'h02, sc), 1, {16'h0002, sc}, 0, id_new);
    d = lcg_byte();
    add_row(make_cmd(id_new, 8'h00, 8'h82, d), 1, make_cmd(id_new, 8'h00, 8'h82, sc),
            0, 24'h0, 1, id_new);
    d = lcg_byte();
    add_row(make_cmd(`CTRL_BCAST_ID, 8'h05, 8'h90, d), 1,
            make_cmd(`CTRL_BCAST_ID, 8'h05, 8'h90, d), 0, 24'h0, 0, id_new);
  endtask

  // ----------------------------------------
  // tx_ctrl monitor
  // ----------------------------------------
  initial begin : tx_monitor
    logic [31:0] f;
    forever begin
      @(posedge clk_sys);
      if (rst_n && tx_ctrl === 1'b0) begin
        // middle of the start bit
        repeat (bit_clks / 2) @(posedge clk_sys);
        for (int i = 0; i < 32; i++) begin
          repeat (bit_clks) @(posedge clk_sys);
          f[line_index(i)] = tx_ctrl;
        end
        repeat (bit_clks) @(posedge clk_sys);
        if (tx_ctrl !== 1'b1) begin
          frame_errors++;
          $display("frame on tx_ctrl at %0t ns has a low stop bit", $time);
        end
        tx_q.push_back(f);
      end
    end
  end

  initial begin : watchdog
    wait (table_built);
    #(longint'(rows.size()) * 4 * frame_ns);
    $display("watchdog expired, the command table did not complete in time");
    $display("SOME TESTS FAILED");
    $finish;
  end

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin : main_seq
    row_t r;
    int   wr_base;
    int   rd_base;
    int   tx_base;
    int   n;
    build_table();
    table_built = 1'b1;
    repeat (3) @(posedge clk_sys);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk_sys);
    check("tx_ctrl", 32'(tx_ctrl), 32'h1);
    check("fx_wr", 32'(fx_wr), 32'h0);
    check("fx_rd", 32'(fx_rd), 32'h0);
    check("dev_id", 32'(dev_id), 32'(`CTRL_DEV_ID_RST));

    for (int k = 0; k < rows.size(); k++) begin
      r = rows[k];
      wr_base = wr_q.size();
      rd_base = rd_q.size();
      tx_base = tx_q.size();
      send_frame(r.frame);
      repeat (2 * frame_clks) @(posedge clk_sys);
      n = tx_q.size() - tx_base;
      check($sformatf("row %0d tx_ctrl frame count", k), 32'(n), 32'(r.has_tx));
      if (r.has_tx && n == 1) begin
        check($sformatf("row %0d tx_ctrl frame", k), tx_q[tx_base], r.tx);
      end
      n = wr_q.size() - wr_base;
      check($sformatf("row %0d fx_wr count", k), 32'(n), 32'(r.has_wr));
      if (r.has_wr && n == 1) begin
        check($sformatf("row %0d fx_waddr and fx_data", k), 32'(wr_q[wr_base]), 32'(r.wr));
      end
      n = rd_q.size() - rd_base;
      check($sformatf("row %0d fx_rd count", k), 32'(n), 32'(r.has_rd));
      if (r.has_rd && n == 1) begin
        check($sformatf("row %0d fx_raddr", k), 32'(rd_q[rd_base]), 32'(bus_addr(r.frame)));
      end
      check($sformatf("row %0d dev_id", k), 32'(dev_id), 32'(r.id));
    end

    errors = errors + frame_errors;
    $display("checks: %0d  errors: %0d  frame errors: %0d", checks, errors, frame_errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
